/* maclaurin_params.svh */
`ifndef MACLAURIN_PARAMS_SVH
`define MACLAURIN_PARAMS_SVH

// ======================================================================
// word widths
// ======================================================================

// x, term and coefficient words are unsigned 0.16 fractions
`define MS_DATA_W 16

// accumulator and result carry 2 integer bits above the fraction
`define MS_ACC_W 18

// term index
`define MS_CNT_W 3

// ======================================================================
// series length and fixed-point constants
// ======================================================================

`define MS_NUM_TERMS 8

// all ones stands for 1.0 in a 0.16 word
`define MS_ONE 16'hFFFF

// same 1.0 in the 2.16 accumulator
`define MS_ACC_ONE 18'h0FFFF

`endif

/* maclaurinPkg.sv */
`default_nettype none

package maclaurinPkg;

  // ======================================================================
  // series selection
  // ======================================================================

  // latched once per run at INIT
  typedef enum logic {
    FUNC_EXP = 1'b0,  // 1 + x + x^2/2! + ...
    FUNC_COS = 1'b1   // 1 - x^2/2! + x^4/4! - ...
  } seriesFunc;

  // ======================================================================
  // sequencer states
  // ======================================================================

  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    INIT  = 3'd1,  // load x, func, term and acc
    MULX  = 3'd2,  // term * x or term * x^2
    MULC  = 3'd3,  // term * coefficient
    ACCUM = 3'd4,  // fold term into acc
    DONE  = 3'd5
  } seriesState;

endpackage

`default_nettype wire

/* seriesControl.sv */
`timescale 1ns/1ns
`default_nettype none

module seriesControl import maclaurinPkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic start,     // level, sampled in IDLE and DONE
  input  logic lastTerm,
  output logic ldInit,
  output logic ldTerm,
  output logic selCoef,   // 0 multiplies by x or x^2, 1 by the table value
  output logic ldAcc,
  output logic cntClear,
  output logic cntUp,
  output logic done
);

  seriesState state;
  seriesState nextState;

  // ======================================================================
  // state register
  // ======================================================================

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  // ======================================================================
  // next state and Moore outputs
  // ======================================================================

  // one init edge, then three edges per term
  always_comb begin
    nextState = state;
    ldInit    = 1'b0;
    ldTerm    = 1'b0;
    selCoef   = 1'b0;
    ldAcc     = 1'b0;
    cntClear  = 1'b0;
    cntUp     = 1'b0;
    done      = 1'b0;
    case (state)
      IDLE: begin
        done = 1'b1;
        if (start) nextState = INIT;
      end
      INIT: begin
        ldInit    = 1'b1;
        cntClear  = 1'b1;  // term index back to 0
        nextState = MULX;
      end
      MULX: begin
        ldTerm    = 1'b1;
        nextState = MULC;
      end
      MULC: begin
        ldTerm    = 1'b1;
        selCoef   = 1'b1;
        nextState = ACCUM;
      end
      ACCUM: begin
        ldAcc     = 1'b1;
        cntUp     = 1'b1;
        nextState = lastTerm ? DONE : MULX;
      end
      DONE: begin
        done = 1'b1;  // result holds here
        if (!start) nextState = IDLE;
      end
      default: nextState = IDLE;
    endcase
  end

endmodule

`default_nettype wire

/* termCounter.sv */
`timescale 1ns/1ns
`default_nettype none

`include "maclaurin_params.svh"

module termCounter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cntClear,
  input  logic                 cntUp,
  output logic [`MS_CNT_W-1:0] termIdx,
  output logic                 lastTerm
);

  localparam int unsigned lastIdx = `MS_NUM_TERMS - 1;

  // clear wins over count
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      termIdx <= '0;
    end else if (cntClear) begin
      termIdx <= '0;
    end else if (cntUp) begin
      termIdx <= termIdx + 1'b1;
    end
  end

  // seen by the FSM in ACCUM of the final term
  assign lastTerm = (termIdx == lastIdx[`MS_CNT_W-1:0]);

endmodule

`default_nettype wire

/* coefficientRom.sv */
`timescale 1ns/1ns
`default_nettype none

`include "maclaurin_params.svh"

module coefficientRom import maclaurinPkg::*; (
  input  seriesFunc             func,
  input  logic [`MS_CNT_W-1:0]  termIdx,
  output logic [`MS_DATA_W-1:0] coef
);

  // ======================================================================
  // reciprocal tables, one row block per series
  // ======================================================================

  always_comb begin
    coef = '0;
    case (func)
      // exp term k gains a factor 1/(k+1)
      FUNC_EXP: begin
        case (termIdx)
          3'd0: coef = 16'hFFFF;  // 1/1
          3'd1: coef = 16'h8000;  // 1/2
          3'd2: coef = 16'h5555;  // 1/3
          3'd3: coef = 16'h4000;  // 1/4
          3'd4: coef = 16'h3333;  // 1/5
          3'd5: coef = 16'h2AAB;  // 1/6
          3'd6: coef = 16'h2492;  // 1/7
          3'd7: coef = 16'h2000;  // 1/8
          default: coef = '0;
        endcase
      end
      // cos term k gains 1/((2k+1)(2k+2))
      FUNC_COS: begin
        case (termIdx)
          3'd0: coef = 16'h8000;  // 1/2
          3'd1: coef = 16'h1555;  // 1/12
          3'd2: coef = 16'h0888;  // 1/30
          3'd3: coef = 16'h0492;  // 1/56
          3'd4: coef = 16'h02D8;  // 1/90
          3'd5: coef = 16'h01F0;  // 1/132
          3'd6: coef = 16'h0168;  // 1/182
          3'd7: coef = 16'h0111;  // 1/240
          default: coef = '0;
        endcase
      end
      default: coef = '0;
    endcase
  end

endmodule

`default_nettype wire

/* termDatapath.sv */
`timescale 1ns/1ns
`default_nettype none

`include "maclaurin_params.svh"

module termDatapath import maclaurinPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`MS_DATA_W-1:0] x,
  input  seriesFunc            func,
  input  logic                 ldInit,
  input  logic                 ldTerm,
  input  logic                 selCoef,
  input  logic                 ldAcc,
  input  logic [`MS_CNT_W-1:0]  termIdx,
  output logic [`MS_ACC_W-1:0]  result
);

  localparam int accPad = `MS_ACC_W - `MS_DATA_W;

  logic [`MS_DATA_W-1:0]   xReg;
  seriesFunc               funcReg;
  logic [`MS_DATA_W-1:0]   termReg;
  logic [`MS_ACC_W-1:0]    accReg;

  logic [`MS_DATA_W-1:0]   coef;
  logic [2*`MS_DATA_W-1:0] xProd;
  logic [`MS_DATA_W-1:0]   xSq;
  logic [`MS_DATA_W-1:0]   mulIn;
  logic [2*`MS_DATA_W-1:0] termProd;
  logic [`MS_DATA_W-1:0]   mulOut;
  logic [`MS_ACC_W-1:0]    termExt;
  logic                    subtract;
  logic [`MS_ACC_W-1:0]    accNext;

  coefficientRom u_coefficientRom (
    .func    (funcReg),
    .termIdx (termIdx),
    .coef    (coef)
  );

  // ======================================================================
  // operand registers
  // ======================================================================

  // run operands, only taken at INIT
  always_ff @(posedge clk) begin
    if (ldInit) begin
      xReg    <= x;
      funcReg <= func;
    end
  end

  always_ff @(posedge clk) begin
    if (ldInit) begin
      termReg <= `MS_ONE;
    end else if (ldTerm) begin
      termReg <= mulOut;
    end
  end

  // ======================================================================
  // shared multiplier
  // ======================================================================

  assign xProd = xReg * xReg;
  assign xSq   = xProd[2*`MS_DATA_W-1:`MS_DATA_W];  // x^2 in 0.16

  // cos steps by x^2 per term, exp by x
  always_comb begin
    if (selCoef) begin
      mulIn = coef;
    end else if (funcReg == FUNC_COS) begin
      mulIn = xSq;
    end else begin
      mulIn = xReg;
    end
  end

  assign termProd = termReg * mulIn;
  assign mulOut   = termProd[2*`MS_DATA_W-1:`MS_DATA_W];  // keep upper half

  // ======================================================================
  // accumulate
  // ======================================================================

  assign termExt  = {{accPad{1'b0}}, termReg};
  assign subtract = (funcReg == FUNC_COS) && !termIdx[0];  // -x^2/2!, +x^4/4!, ...
  assign accNext  = subtract ? accReg - termExt : accReg + termExt;  // wraps in 18 bits

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      accReg <= '0;
    end else if (ldInit) begin
      accReg <= `MS_ACC_ONE;
    end else if (ldAcc) begin
      accReg <= accNext;
    end
  end

  assign result = accReg;

endmodule

`default_nettype wire

/* maclaurinSeriesCalculator.sv */
`timescale 1ns/1ns
`default_nettype none

`include "maclaurin_params.svh"

module maclaurinSeriesCalculator import maclaurinPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 start,
  input  logic [`MS_DATA_W-1:0] x,
  input  seriesFunc            func,
  output logic [`MS_ACC_W-1:0]  result,
  output logic                 done
);

  // ======================================================================
  // control strobes
  // ======================================================================

  logic                ldInit;
  logic                ldTerm;
  logic                selCoef;
  logic                ldAcc;
  logic                cntClear;
  logic                cntUp;
  logic                lastTerm;
  logic [`MS_CNT_W-1:0] termIdx;

  seriesControl u_seriesControl (
    .clk      (clk),
    .rst      (rst),
    .start    (start),
    .lastTerm (lastTerm),
    .ldInit   (ldInit),
    .ldTerm   (ldTerm),
    .selCoef  (selCoef),
    .ldAcc    (ldAcc),
    .cntClear (cntClear),
    .cntUp    (cntUp),
    .done     (done)
  );

  termCounter u_termCounter (
    .clk      (clk),
    .rst      (rst),
    .cntClear (cntClear),
    .cntUp    (cntUp),
    .termIdx  (termIdx),
    .lastTerm (lastTerm)
  );

  // one datapath serves both series
  termDatapath u_termDatapath (
    .clk     (clk),
    .rst     (rst),
    .x       (x),
    .func    (func),
    .ldInit  (ldInit),
    .ldTerm  (ldTerm),
    .selCoef (selCoef),
    .ldAcc   (ldAcc),
    .termIdx (termIdx),
    .result  (result)
  );

endmodule

`default_nettype wire

/* maclaurinSeriesCalculator_props.sv */
`timescale 1ns/1ns
`default_nettype none

`include "maclaurin_params.svh"

module maclaurinSeriesCalculator_props import maclaurinPkg::*; (
  input logic                 clk,
  input logic                 rst,
  input logic                 start,
  input logic                 done,
  input logic [`MS_ACC_W-1:0] result,
  input seriesState           state
);

  localparam int runLatency = 1 + 3 * `MS_NUM_TERMS;

  // edges since the accepting edge, 0 outside a run
  int unsigned runEdges;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      runEdges <= 0;
    end else if (state == IDLE && start) begin
      runEdges <= 1;
    end else if (runEdges != 0 && runEdges < runLatency) begin
      runEdges <= runEdges + 1;
    end else begin
      runEdges <= 0;
    end
  end

  // done stays low from INIT through the last ACCUM
  busyNotDone: assert property (@(posedge clk) disable iff (rst)
    (runEdges != 0) |-> !done)
    else $error("done high while the FSM is busy");

  // falls right after the accepting edge
  fallOnStart: assert property (@(posedge clk) disable iff (rst)
    $fell(done) |-> $past(state == IDLE && start))
    else $error("done fell without an accepted start");

  // rise is sampled one edge after the final ACCUM edge
  riseLatency: assert property (@(posedge clk) disable iff (rst)
    $rose(done) |-> $past(state == IDLE && start, runLatency + 1))
    else $error("done rose at the wrong distance from the accepting edge");

  resultHeld: assert property (@(posedge clk) disable iff (rst)
    (state == DONE && $past(state) == DONE) |-> $stable(result))
    else $error("result changed while in DONE");

endmodule

`default_nettype wire

/* maclaurinSeriesCalculator_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "maclaurin_params.svh"

module maclaurinSeriesCalculator_tb import maclaurinPkg::*; ();

  localparam int clkPeriod  = 40;
  localparam int numRuns    = 200;
  localparam int runLatency = 1 + 3 * `MS_NUM_TERMS;  // init edge, then three edges per term
  localparam int doneWait   = 2 * runLatency;
  localparam int cycleLimit = numRuns * 40;  // one run with hold and idle gap stays under 40

  // reciprocal tables, 1/(k+1) and 1/((2k+1)(2k+2))
  localparam logic [15:0] expCoef [8] = '{16'hFFFF, 16'h8000, 16'h5555, 16'h4000,
                                          16'h3333, 16'h2AAB, 16'h2492, 16'h2000};
  localparam logic [15:0] cosCoef [8] = '{16'h8000, 16'h1555, 16'h0888, 16'h0492,
                                          16'h02D8, 16'h01F0, 16'h0168, 16'h0111};
  localparam logic [15:0] cornerX [3] = '{16'h0000, 16'hFFFF, 16'h8000};

  logic                  clk;
  logic                  rst;
  logic                  start;
  logic [`MS_DATA_W-1:0] x;
  seriesFunc             func;
  logic [`MS_ACC_W-1:0]  result;
  logic                  done;

  int errorCount = 0;
  int cycleCount = 0;
  int runCount;

  maclaurinSeriesCalculator i_maclaurinSeriesCalculator (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .x      (x),
    .func   (func),
    .result (result),
    .done   (done)
  );

  bind maclaurinSeriesCalculator maclaurinSeriesCalculator_props u_props (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .done   (done),
    .result (result),
    .state  (u_seriesControl.state)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // ======================================================================
  // reference model, upper 16 bits kept after every product
  // ======================================================================

  function automatic logic [`MS_ACC_W-1:0] modelSeries(input logic [15:0] xIn,
                                                        input seriesFunc fIn);
    longint unsigned term;
    longint unsigned step;
    longint unsigned acc;
    longint unsigned coef;
    term = 64'hFFFF;
    acc  = 64'h0FFFF;
    step = (fIn == FUNC_COS) ? ((longint'(xIn) * longint'(xIn)) >> 16) : longint'(xIn);
    for (int k = 0; k < `MS_NUM_TERMS; k++) begin
      coef = (fIn == FUNC_COS) ? longint'(cosCoef[k]) : longint'(expCoef[k]);
      term = (term * step) >> 16;
      term = (term * coef) >> 16;
      if (fIn == FUNC_COS && (k % 2) == 0) begin
        acc = acc - term;  // -x^2/2!, -x^6/6!, ...
      end else begin
        acc = acc + term;
      end
      acc = acc & 64'h3FFFF;  // 18-bit wrap
    end
    return acc[`MS_ACC_W-1:0];
  endfunction

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
    errorCount++;
    $display("[ERROR] %0t ns: %s expected 'h%0h got 'h%0h", $time, name, expected, got);
  endtask

  // ======================================================================
  // one run: start, wait for done, check, hold, release
  // ======================================================================

  task automatic runOnce(input logic [15:0] xIn, input seriesFunc fIn, input bit disturb,
                         input int holdCycles);
    logic [`MS_ACC_W-1:0] expected;
    int                   edges;
    expected = modelSeries(xIn, fIn);
    @(negedge clk);
    start = 1'b1;
    x     = xIn;
    func  = fIn;
    @(posedge clk);  // accepting edge
    edges = 0;
    @(negedge clk);
    if (holdCycles == 0) start = 1'b0;  // ignored while busy
    if (done !== 1'b0) reportMismatch("done", done, 0);
    while (done !== 1'b1 && edges < doneWait) begin
      if (disturb && edges == 1) begin  // operands already latched at INIT
        x    = 16'($urandom);
        func = seriesFunc'(1'($urandom));
      end
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    if (done !== 1'b1) begin
      errorCount++;
      $display("done did not rise within %0d cycles of start at %0t ns", doneWait, $time);
    end else begin
      if (edges != runLatency) reportMismatch("done latency", edges, runLatency);
      if (result !== expected) reportMismatch("result", result, expected);
      if (fIn == FUNC_EXP && xIn == 16'h0000 && result !== `MS_ACC_ONE) begin
        reportMismatch("result", result, `MS_ACC_ONE);
      end
    end
    repeat (holdCycles) begin
      @(negedge clk);
      if (done !== 1'b1) reportMismatch("done", done, 1);
      if (result !== expected) reportMismatch("result", result, expected);
    end
    start = 1'b0;
    @(negedge clk);  // back in IDLE
    if (done !== 1'b1) reportMismatch("done", done, 1);
  endtask

  // ======================================================================
  // main sequence
  // ======================================================================

  initial begin
    logic [15:0] xPick;
    seriesFunc   fPick;
    rst   = 1'b1;
    start = 1'b0;
    x     = '0;
    func  = FUNC_EXP;
    void'($urandom(63155));
    repeat (4) @(posedge clk);
    @(negedge clk);
    if (done !== 1'b1) reportMismatch("done", done, 1);
    if (result !== '0) reportMismatch("result", result, 0);
    rst = 1'b0;
    for (runCount = 0; runCount < numRuns; runCount++) begin
      if (runCount < 6) begin  // corners first, both series each
        xPick = cornerX[runCount / 2];
        fPick = seriesFunc'(runCount[0]);
      end else begin
        xPick = 16'($urandom);
        fPick = seriesFunc'(1'($urandom));
        if ($urandom_range(9, 0) == 0) xPick = cornerX[$urandom_range(2, 0)];
      end
      runOnce(xPick, fPick, ($urandom_range(3, 0) == 0), int'($urandom_range(3, 0)));
    end
    $display("runs: %0d, errors: %0d", numRuns, errorCount);
    if (errorCount == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // hang guard
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("run stopped after %0d cycles before all runs finished, errors so far: %0d",
               cycleCount, errorCount);
      $display("TEST FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* maclaurinSeriesCalculator.f */
+incdir+.
maclaurinPkg.sv
seriesControl.sv
termCounter.sv
coefficientRom.sv
termDatapath.sv
maclaurinSeriesCalculator.sv
maclaurinSeriesCalculator_props.sv
maclaurinSeriesCalculator_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := maclaurinSeriesCalculator_tb
FILELIST  := maclaurinSeriesCalculator.f
VFLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SOURCES   := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard *.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# an aborted simulation counts as a failure
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || echo "TEST FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
